// ==== flist.f ====
+incdir+.
board_pkg.sv
spi_slave.sv
led_matrix_scan.sv
saw_gen.sv
pdm_mod.sv
board_top.sv
board_top_sva.sv
board_top_tb.sv

// ==== Bender.yml ====
package:
  name: board_ctrl

export_include_dirs:
  - .

sources:
  - files:
      - board_pkg.sv
      - spi_slave.sv
      - led_matrix_scan.sv
      - saw_gen.sv
      - pdm_mod.sv
      - board_top.sv

  - target: test
    files:
      - board_top_sva.sv
      - board_top_tb.sv

// ==== board_top_tb.sv ====
`timescale 1ns/1ps
`include "board_params.svh"

module board_top_tb import board_pkg::*; ();

  localparam int W          = `BOARD_WORD_BITS;
  localparam int SCAN_LOG2  = `BOARD_SCAN_DIV_LOG2;
  localparam int WAVE_BITS  = 6;
  localparam int SAW_STEP   = 8;
  localparam int CLK_PERIOD = 4;
  localparam int HOLD       = 6;          // clocks each SPI level is held
  localparam int ROWS       = 7;
  localparam int WAVE_CLKS  = (1 << WAVE_BITS) * SAW_STEP;

  // clocks spent per table row for the frame and the scanner check
  localparam int FRAME_CLKS = 1 + HOLD * (2 * W + 3);
  localparam int SCAN_CLKS  = 33 * (1 << SCAN_LOG2) + 2;
  localparam int LIMIT_CLKS = 2 * (16 + ROWS * (FRAME_CLKS + SCAN_CLKS) + 2 * WAVE_CLKS + 20);

  logic                 clk;
  logic                 rst;
  logic                 cfg_sck;
  logic                 cfg_cs;
  logic                 cfg_si;
  logic                 cfg_so;
  led_word_t            pin_in;
  matrix_line_t         aled;
  matrix_line_t         kled_tri;
  logic [WAVE_BITS-1:0] wave_level;
  logic                 pdm_out;

  // stimulus table
  led_word_t word_tab [ROWS];
  led_word_t pin_tab  [ROWS];
  led_word_t exp_tab  [ROWS];

  logic [31:0] lfsr;
  int unsigned cyc;           // clocks since reset release

  board_top #(
    .WAVE_BITS (WAVE_BITS),
    .SAW_STEP  (SAW_STEP)
  ) uut (
    .clk        (clk),
    .rst        (rst),
    .cfg_sck    (cfg_sck),
    .cfg_cs     (cfg_cs),
    .cfg_si     (cfg_si),
    .cfg_so     (cfg_so),
    .pin_in     (pin_in),
    .aled       (aled),
    .kled_tri   (kled_tri),
    .wave_level (wave_level),
    .pdm_out    (pdm_out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    if (rst) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  // watchdog
  initial begin
    #(LIMIT_CLKS * CLK_PERIOD);
    $display("timeout: the test did not finish in %0d clocks", LIMIT_CLKS);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped by the watchdog");
  end

  // galois form with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      lfsr_next = (s >> 1) ^ 32'h8020_0003;
    end else begin
      lfsr_next = s >> 1;
    end
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    int i;
    val = '0;
    for (i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp, input int tol);
    int diff;
    diff = int'(got) - int'(exp);
    if ((^got === 1'bx) || diff > tol || diff < -tol) begin
      $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "check on %s failed", name);
    end
  endtask

  // ends 1 ns after a rising edge where inputs are driven
  task automatic tick(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // one full frame sent MSB first with reply bits collected before each rise
  task automatic spi_frame(input led_word_t word, input led_word_t pins,
                           input led_word_t exp_rd);
    led_word_t rd;
    int b;
    rd = '0;
    tick(1);
    pin_in = pins;
    cfg_cs = 1'b0;
    tick(HOLD);
    for (b = W - 1; b >= 0; b--) begin
      cfg_si = word[b];        // sck is low here
      tick(HOLD);
      rd[b]   = cfg_so;
      cfg_sck = 1'b1;
      tick(HOLD);
      cfg_sck = 1'b0;
    end
    tick(HOLD);
    cfg_cs = 1'b1;
    tick(HOLD);
    check_value("cfg_so", rd, exp_rd, 0);
  endtask

  // follow 16 scan steps with the index worked out from clocks since reset
  task automatic scan_check(input led_word_t pattern);
    matrix_line_t prev;
    matrix_line_t exp_a;
    matrix_line_t exp_k;
    scan_idx_t    idx;
    logic [15:0]  seen;
    int           n;
    int           j;
    seen = '0;
    n    = 0;
    @(negedge clk);
    prev = aled;
    while (n < 16) begin
      @(negedge clk);
      if (aled !== prev) begin
        idx = scan_idx_t'((cyc >> SCAN_LOG2) - 1);
        for (j = 0; j < 4; j++) begin
          exp_a[j] = (j != idx[1:0]);                  // only the column anode is low
          exp_k[j] = pattern[idx] && (j == idx[3:2]);  // row enabled when the LED is lit
        end
        check_value("aled", aled, exp_a, 0);
        check_value("kled_tri", kled_tri, exp_k, 0);
        seen[idx] = 1'b1;
        prev      = aled;
        n++;
      end
    end
    check_value("scan indices seen", seen, 16'hffff, 0);
  endtask

  // ramp shape and pdm density over one sawtooth period
  task automatic wave_check();
    logic [WAVE_BITS-1:0] prev;
    logic [WAVE_BITS-1:0] last;
    logic [WAVE_BITS-1:0] exp_lvl;
    int since;
    int changes;
    int ones;
    int level_sum;
    int i;
    since     = 0;
    changes   = 0;
    ones      = 0;
    level_sum = 0;
    @(negedge clk);
    prev = wave_level;
    while (wave_level === prev) @(negedge clk);
    prev = wave_level;
    last = wave_level;
    for (i = 0; i < WAVE_CLKS; i++) begin
      @(negedge clk);
      since++;
      ones      += pdm_out;
      level_sum += last;       // pdm_out lags its level by one clock
      last       = wave_level;
      if (wave_level !== prev) begin
        if (prev == 0) begin
          exp_lvl = (1 << WAVE_BITS) - 1;   // wraps back to full scale
        end else begin
          exp_lvl = prev - 1;
        end
        check_value("wave_level", wave_level, exp_lvl, 0);
        check_value("wave_level step clocks", since, SAW_STEP, 0);
        since = 0;
        prev  = wave_level;
        changes++;
      end
    end
    check_value("wave_level changes", changes, 1 << WAVE_BITS, 0);
    check_value("pdm_out ones", ones, level_sum >> WAVE_BITS, 1);
  endtask

  initial begin
    logic [31:0] v;
    int r;
    rst     = 1'b1;
    cfg_sck = 1'b0;
    cfg_cs  = 1'b1;
    cfg_si  = 1'b0;
    pin_in  = '0;
    lfsr    = 32'hf17d;

    word_tab[0] = 16'h0000;
    pin_tab[0]  = 16'h0000;
    word_tab[1] = 16'hffff;
    pin_tab[1]  = 16'hffff;
    word_tab[2] = 16'ha5c3;
    pin_tab[2]  = 16'ha5c3;
    word_tab[3] = 16'h8001;
    pin_tab[3]  = 16'h8001;
    for (r = 4; r < ROWS; r++) begin
      take_bits(W, v);
      word_tab[r] = v[W-1:0];
      take_bits(W, v);
      pin_tab[r] = v[W-1:0];
    end
    for (r = 0; r < ROWS; r++) begin
      exp_tab[r] = pin_tab[r];
    end

    tick(16);
    rst = 1'b0;

    check_value("cfg_so", cfg_so, 1'b1, 0);
    check_value("aled", aled, 4'hf, 0);
    check_value("kled_tri", kled_tri, 4'h0, 0);
    check_value("pdm_out", pdm_out, 1'b0, 0);
    check_value("wave_level", wave_level, (1 << WAVE_BITS) - 1, 0);

    for (r = 0; r < ROWS; r++) begin
      spi_frame(word_tab[r], pin_tab[r], exp_tab[r]);
      tick(17 * (1 << SCAN_LOG2));    // let the new pattern reach every LED
      scan_check(word_tab[r]);
    end

    wave_check();

    if (uut.sva_chk.fail_count == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("ERRORS FOUND");
      $fatal(1, "%0d assertion failures in board_top_sva", uut.sva_chk.fail_count);
    end
  end

endmodule

// ==== board_top_sva.sv ====
`timescale 1ns/1ps

module board_top_sva import board_pkg::*; (
  input logic         clk,
  input logic         rst,
  input matrix_line_t aled,
  input matrix_line_t kled_tri,
  input logic         word_strobe
);

  int fail_count = 0;   // read by the testbench at the end

  // at most one anode driven low
  a_aled_one_cold: assert property (
    @(posedge clk) disable iff (rst)
    ($onehot(~aled) || aled == 4'hf)
  ) else begin
    fail_count++;
    $error("aled 0x%h has more than one anode active", aled);
  end

  // at most one cathode row enabled
  a_kled_one_hot: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(kled_tri)
  ) else begin
    fail_count++;
    $error("kled_tri 0x%h has more than one row enabled", kled_tri);
  end

  a_strobe_single: assert property (
    @(posedge clk) disable iff (rst)
    word_strobe |=> !word_strobe
  ) else begin
    fail_count++;
    $error("word_strobe held high for two cycles");
  end

endmodule

bind board_top board_top_sva sva_chk (
  .clk         (clk),
  .rst         (rst),
  .aled        (aled),
  .kled_tri    (kled_tri),
  .word_strobe (word_strobe)
);

// ==== board_top.sv ====
`timescale 1ns/1ps
`include "board_params.svh"

module board_top import board_pkg::*; #(
  parameter int WAVE_BITS = `BOARD_WAVE_BITS,
  parameter int SAW_STEP  = `BOARD_SAW_STEP
) (
  input  logic                 clk,
  input  logic                 rst,
  // SPI from the host controller
  input  logic                 cfg_sck,
  input  logic                 cfg_cs,
  input  logic                 cfg_si,
  output logic                 cfg_so,
  input  led_word_t            pin_in,     // read back on every frame
  // LED matrix
  output matrix_line_t         aled,
  output matrix_line_t         kled_tri,
  // dimming path
  output logic [WAVE_BITS-1:0] wave_level,
  output logic                 pdm_out
);

  led_word_t led_bits;
  logic      word_strobe;   // one clock per received word

  spi_slave u_spi (
    .clk         (clk),
    .rst         (rst),
    .cfg_sck     (cfg_sck),
    .cfg_cs      (cfg_cs),
    .cfg_si      (cfg_si),
    .cfg_so      (cfg_so),
    .pin_in      (pin_in),
    .led_bits    (led_bits),
    .word_strobe (word_strobe)
  );

  led_matrix_scan u_scan (
    .clk      (clk),
    .rst      (rst),
    .led_bits (led_bits),
    .aled     (aled),
    .kled_tri (kled_tri)
  );

  saw_gen #(
    .WAVE_BITS (WAVE_BITS),
    .SAW_STEP  (SAW_STEP)
  ) u_saw (
    .clk        (clk),
    .rst        (rst),
    .wave_level (wave_level)
  );

  // sawtooth level sets the LED brightness
  pdm_mod #(
    .WAVE_BITS (WAVE_BITS)
  ) u_pdm (
    .clk     (clk),
    .rst     (rst),
    .level   (wave_level),
    .pdm_out (pdm_out)
  );

endmodule

// ==== pdm_mod.sv ====
`timescale 1ns/1ps
`include "board_params.svh"

module pdm_mod #(
  parameter int WAVE_BITS = `BOARD_WAVE_BITS
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [WAVE_BITS-1:0] level,
  output logic                 pdm_out
);

  // first order sigma-delta
  // the carry out of the accumulator is the output bit, so over
  // 2^WAVE_BITS clocks exactly level ones come out

  logic [WAVE_BITS-1:0] acc;
  logic [WAVE_BITS:0]   sum;    // one extra bit for the carry

  assign sum = {1'b0, acc} + {1'b0, level};

  always_ff @(posedge clk) begin
    if (rst) begin
      acc     <= '0;
      pdm_out <= 1'b0;
    end else begin
      acc     <= sum[WAVE_BITS-1:0];   // residue carried on
      pdm_out <= sum[WAVE_BITS];
    end
  end

endmodule

// ==== saw_gen.sv ====
`timescale 1ns/1ps
`include "board_params.svh"

module saw_gen #(
  parameter int WAVE_BITS = `BOARD_WAVE_BITS,
  parameter int SAW_STEP  = `BOARD_SAW_STEP
) (
  input  logic                 clk,
  input  logic                 rst,
  output logic [WAVE_BITS-1:0] wave_level
);

  localparam int DIV_BITS = $clog2(SAW_STEP + 1);
  localparam logic [DIV_BITS-1:0] DIV_LAST = DIV_BITS'(SAW_STEP - 1);

  logic [DIV_BITS-1:0] div_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      div_cnt    <= '0;
      wave_level <= '1;             // start at full scale
    end else if (div_cnt == DIV_LAST) begin
      div_cnt    <= '0;
      // falls through zero into full scale again
      wave_level <= wave_level - 1'b1;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

endmodule

// ==== led_matrix_scan.sv ====
`timescale 1ns/1ps
`include "board_params.svh"

module led_matrix_scan import board_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  led_word_t    led_bits,
  output matrix_line_t aled,      // anodes, active low
  output matrix_line_t kled_tri   // cathode enables, active high
);

  localparam int DIV_BITS = `BOARD_SCAN_DIV_LOG2;

  logic [DIV_BITS-1:0] prescale;
  logic                step;
  scan_idx_t           idx;

  // column and row of the current LED
  logic [1:0] col;
  logic [1:0] row;

  // free running, one step per 2^DIV_BITS clocks
  always_ff @(posedge clk) begin
    if (rst) begin
      prescale <= '0;
    end else begin
      prescale <= prescale + 1'b1;
    end
  end

  assign step = &prescale;

  assign col = idx[1:0];
  assign row = idx[3:2];

  always_ff @(posedge clk) begin
    if (rst) begin
      idx <= '0;
    end else if (step) begin
      idx <= idx + 1'b1;    // wraps after LED 15
    end
  end

  // one LED at a time, pattern sampled as the outputs update
  always_ff @(posedge clk) begin
    if (rst) begin
      aled     <= '1;       // all anodes off
      kled_tri <= '0;       // all cathodes floating
    end else if (step) begin
      aled <= ~(matrix_line_t'(1) << col);
      if (led_bits[idx]) begin
        kled_tri <= matrix_line_t'(1) << row;
      end else begin
        kled_tri <= '0;
      end
    end
  end

endmodule

// ==== spi_slave.sv ====
`timescale 1ns/1ps
`include "board_params.svh"

module spi_slave import board_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      cfg_sck,
  input  logic      cfg_cs,
  input  logic      cfg_si,
  output logic      cfg_so,
  input  led_word_t pin_in,
  output led_word_t led_bits,
  output logic      word_strobe
);

  localparam int W = `BOARD_WORD_BITS;

  // [0] and [1] are the synchronizer, [2] holds the previous value for edges
  logic [2:0] sck_sync;
  logic [2:0] cs_sync;
  logic [1:0] si_sync;    // data only needs the two stages

  logic sck_rise;
  logic cs_rise;
  logic cs_fall;
  logic selected;

  led_word_t rx_shift;    // incoming word, MSB arrives first
  led_word_t tx_shift;    // reply word

  // bus pins are asynchronous to clk
  always_ff @(posedge clk) begin
    if (rst) begin
      sck_sync <= '0;
      cs_sync  <= '1;     // idle deselected, no false edge out of reset
    end else begin
      sck_sync <= {sck_sync[1:0], cfg_sck};
      cs_sync  <= {cs_sync[1:0], cfg_cs};
    end
  end

  always_ff @(posedge clk) begin
    si_sync <= {si_sync[0], cfg_si};
  end

  assign sck_rise = sck_sync[1] & ~sck_sync[2];
  assign cs_rise  = cs_sync[1] & ~cs_sync[2];
  assign cs_fall  = ~cs_sync[1] & cs_sync[2];
  assign selected = ~cs_sync[1];

  // receive side, keeps the last W bits of a frame
  always_ff @(posedge clk) begin
    if (sck_rise && selected) begin
      rx_shift <= {rx_shift[W-2:0], si_sync[1]};
    end
  end

  // reply side
  // pins are snapshot at the start of the frame and leave MSB first
  always_ff @(posedge clk) begin
    if (rst) begin
      tx_shift <= '1;
    end else if (cs_fall) begin
      tx_shift <= pin_in;
    end else if (sck_rise && selected) begin
      tx_shift <= {tx_shift[W-2:0], 1'b1}; // ones fill in behind
    end
  end

  assign cfg_so = tx_shift[W-1];

  // end of frame, the word goes to the LEDs
  always_ff @(posedge clk) begin
    if (rst) begin
      led_bits    <= '0;
      word_strobe <= 1'b0;
    end else begin
      word_strobe <= cs_rise;
      if (cs_rise) begin
        led_bits <= rx_shift;
      end
    end
  end

endmodule

// ==== board_pkg.sv ====
`include "board_params.svh"

package board_pkg;

  // SPI word, LED pattern and pin snapshot all share this layout
  // bit n drives LED n, read back MSB first
  typedef logic [`BOARD_WORD_BITS-1:0] led_word_t;

  // LED position in the matrix
  // [3:2] row, picks the cathode
  // [1:0] column, picks the anode
  typedef logic [3:0] scan_idx_t;

  // one line of the matrix, anodes or cathode enables
  typedef logic [3:0] matrix_line_t;

endpackage

// ==== board_params.svh ====
`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

// SPI word width, also the number of LEDs in the 4x4 matrix
`define BOARD_WORD_BITS 16

// log2 of clocks per scan step
// 5 gives one LED every 32 clocks, a full frame every 512
`define BOARD_SCAN_DIV_LOG2 5

// default resolution of the waveform level
`define BOARD_WAVE_BITS 10

// default clocks per sawtooth step
// with 10 bits this is one ramp per 1024 * 100000 clocks
`define BOARD_SAW_STEP 100000

`endif
